// ==== Makefile ====
# Verilator simulation of the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= ** FAIL **
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

# An abnormal exit is logged as a failure, then the log decides
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -qF "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
design/riscv_isa_pkg.sv
design/mem_map_pkg.sv
design/mem_req_if.sv
design/mem_control.sv
design/store_pack.sv
design/dmem.sv
design/io_counters.sv
design/load_unit.sv
design/mem_stage.sv
dv/tb_clock.sv
dv/mem_stage_sva.sv
dv/tb_mem_stage.sv

// ==== design/dmem.sv ====
module dmem (
    input  logic        clk,
    mem_req_if.consumer req,
    output logic [31:0] rdata
);
    import mem_map_pkg::*;

    // Word-wide storage, written byte by byte
    logic [31:0] mem [2**DMEM_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (req.dmem_en) begin
            // Per-byte write enables
            for (int i = 0; i < 4; i++) begin
                if (req.wmask[i]) begin
                    mem[req.word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
            // Registered read, old data on a write
            rdata <= mem[req.word_addr];
        end
    end

endmodule

// ==== design/io_counters.sv ====
module io_counters (
    input  logic        clk,
    input  logic        rst_n,
    mem_req_if.consumer req,
    input  logic        is_branch,
    input  logic        br_suc,
    input  logic [31:0] wb_inst,
    output logic [31:0] rdata
);
    import riscv_isa_pkg::*;
    import mem_map_pkg::*;

    logic [31:0] cycle_cnt;
    logic [31:0] instret_cnt;
    logic [31:0] br_total_cnt;
    logic [31:0] br_correct_cnt;
    logic [7:0]  reg_offset;
    logic        cnt_clear;

    // Byte offset inside the I/O region
    assign reg_offset = {req.word_addr[5:0], 2'b00};

    // Any store to the reset register clears all four
    assign cnt_clear = req.io_en && (req.wmask != 4'b0000) && (reg_offset == IO_CNT_RESET);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt      <= '0;
            instret_cnt    <= '0;
            br_total_cnt   <= '0;
            br_correct_cnt <= '0;
        end else if (cnt_clear) begin
            cycle_cnt      <= '0;
            instret_cnt    <= '0;
            br_total_cnt   <= '0;
            br_correct_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
            // Retired means anything but a bubble in WB
            if (wb_inst != NOP) begin
                instret_cnt <= instret_cnt + 32'd1;
            end
            // Branches counted as they pass MEM
            if (is_branch) begin
                br_total_cnt <= br_total_cnt + 32'd1;
            end
            if (is_branch && br_suc) begin
                br_correct_cnt <= br_correct_cnt + 32'd1;
            end
        end
    end

    // Read data one cycle after the request
    always_ff @(posedge clk) begin
        if (req.io_en) begin
            case (reg_offset)
                IO_CYCLE:      rdata <= cycle_cnt;
                IO_INSTRET:    rdata <= instret_cnt;
                IO_BR_TOTAL:   rdata <= br_total_cnt;
                IO_BR_CORRECT: rdata <= br_correct_cnt;
                // Reset register and holes read as zero
                default:       rdata <= '0;
            endcase
        end
    end

endmodule

// ==== design/load_unit.sv ====
module load_unit (
    input  logic [31:0] wb_inst,
    input  logic [31:0] wb_alu,
    input  logic        io_sel,
    input  logic [31:0] dmem_rdata,
    input  logic [31:0] io_rdata,
    output logic [31:0] load_data
);
    import riscv_isa_pkg::*;

    opcode_e     wb_opcode;
    mem_size_e   wb_size;
    logic [31:0] word;
    logic [31:0] shifted;

    assign wb_opcode = opcode_e'(wb_inst[OPCODE_MSB:OPCODE_LSB]);
    assign wb_size   = mem_size_e'(wb_inst[FUNCT3_MSB:FUNCT3_LSB]);

    // Region chosen one cycle ago
    assign word = io_sel ? io_rdata : dmem_rdata;

    // Addressed byte or halfword down to bit 0
    assign shifted = word >> {wb_alu[1:0], 3'b000};

    always_comb begin
        if (wb_opcode != OPC_LOAD) begin
            // Non-loads give nothing
            load_data = '0;
        end else begin
            case (wb_size)
                SIZE_B:  load_data = {{24{shifted[7]}}, shifted[7:0]};
                SIZE_H:  load_data = {{16{shifted[15]}}, shifted[15:0]};
                SIZE_BU: load_data = {24'd0, shifted[7:0]};
                SIZE_HU: load_data = {16'd0, shifted[15:0]};
                // Word loads are aligned, no shift left
                default: load_data = word;
            endcase
        end
    end

endmodule

// ==== design/mem_control.sv ====
module mem_control (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               inst,
    input  logic [31:0]               wb_inst,
    input  logic [31:0]               addr,
    mem_req_if.ctrl                   req,
    output logic                      fwd_sel,
    output riscv_isa_pkg::mem_size_e  size,
    output logic                      is_branch,
    output logic                      wb_io_sel
);
    import riscv_isa_pkg::*;
    import mem_map_pkg::*;

    opcode_e    opcode;
    opcode_e    wb_opcode;
    logic       is_load;
    logic       is_store;
    logic       is_io;
    logic       wb_writes_rd;
    logic [4:0] wb_rd;
    logic [4:0] rs2;

    // Field extraction for MEM and WB instructions
    assign opcode    = opcode_e'(inst[OPCODE_MSB:OPCODE_LSB]);
    assign wb_opcode = opcode_e'(wb_inst[OPCODE_MSB:OPCODE_LSB]);
    assign size      = mem_size_e'(inst[FUNCT3_MSB:FUNCT3_LSB]);
    assign rs2       = inst[RS2_MSB:RS2_LSB];
    assign wb_rd     = wb_inst[RD_MSB:RD_LSB];

    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_branch = (opcode == OPC_BRANCH);

    // Top nibble picks the region
    assign is_io = (addr[31:28] == IO_BASE);

    // Exactly one side sees a load or store
    assign req.dmem_en = (is_load || is_store) && !is_io;
    assign req.io_en   = (is_load || is_store) && is_io;

    // Instructions in WB that write back to rd
    always_comb begin
        case (wb_opcode)
            OPC_LOAD, OPC_OP, OPC_OP_IMM, OPC_LUI,
            OPC_AUIPC, OPC_JAL, OPC_JALR: wb_writes_rd = 1'b1;
            default:                      wb_writes_rd = 1'b0;
        endcase
    end

    // Store operand comes from WB on an rs2 hazard, x0 never forwards
    assign fwd_sel = is_store && wb_writes_rd && (wb_rd != 5'd0) && (wb_rd == rs2);

    // WB-side word select follows the read by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_io_sel <= 1'b0;
        end else begin
            wb_io_sel <= is_load && is_io;
        end
    end

endmodule

// ==== design/mem_map_pkg.sv ====
package mem_map_pkg;

    // Data RAM depth as word-address bits
    localparam int DMEM_ADDR_BITS = 12;

    // Address bits 31:28 that select the I/O region
    localparam logic [3:0] IO_BASE = 4'h8;

    // Byte offsets of the I/O registers inside the region
    typedef enum logic [7:0] {
        IO_CYCLE      = 8'h10,
        IO_INSTRET    = 8'h14,
        IO_CNT_RESET  = 8'h18,
        IO_BR_TOTAL   = 8'h1C,
        IO_BR_CORRECT = 8'h20
    } io_reg_e;

endpackage

// ==== design/mem_req_if.sv ====
interface mem_req_if;
    import mem_map_pkg::*;

    // One aligned request, shared by the RAM and the I/O block
    logic [DMEM_ADDR_BITS-1:0] word_addr;
    logic [31:0]               wdata;
    // Zero mask means a read
    logic [3:0]                wmask;
    logic                      dmem_en;
    logic                      io_en;

    // Region enables from the decoder
    modport ctrl (output dmem_en, io_en);
    // Address and lane data from the store packer
    modport packer (output word_addr, wdata, wmask);
    modport consumer (input word_addr, wdata, wmask, dmem_en, io_en);
endinterface

// ==== design/mem_stage.sv ====
module mem_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] mem_pc,
    input  logic [31:0] mem_alu,
    input  logic [31:0] mem_rd2,
    input  logic [31:0] mem_inst,
    input  logic        mem_br_suc,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_pc4,
    output logic [31:0] wb_alu,
    output logic [31:0] wb_inst,
    output logic [31:0] wb_load_data
);
    import riscv_isa_pkg::*;

    mem_size_e   size;
    logic [31:0] pc4;
    logic [31:0] dmem_rdata;
    logic [31:0] io_rdata;
    logic        fwd_sel;
    logic        is_branch;
    logic        is_store;
    logic        wb_io_sel;

    // Request seen by both RAM and counters
    mem_req_if req ();

    assign pc4      = mem_pc + 32'd4;
    assign is_store = (mem_inst[OPCODE_MSB:OPCODE_LSB] == OPC_STORE);

    // Enables, forwarding and size
    mem_control i_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (mem_inst),
        .wb_inst   (wb_inst),
        .addr      (mem_alu),
        .req       (req.ctrl),
        .fwd_sel   (fwd_sel),
        .size      (size),
        .is_branch (is_branch),
        .wb_io_sel (wb_io_sel)
    );

    // Lane alignment and write mask
    store_pack i_store_pack (
        .rd2       (mem_rd2),
        .wdata_fwd (wb_wdata),
        .fwd_sel   (fwd_sel),
        .addr      (mem_alu),
        .size      (size),
        .is_store  (is_store),
        .req       (req.packer)
    );

    dmem i_dmem (
        .clk   (clk),
        .req   (req.consumer),
        .rdata (dmem_rdata)
    );

    io_counters i_io (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req.consumer),
        .is_branch (is_branch),
        .br_suc    (mem_br_suc),
        .wb_inst   (wb_inst),
        .rdata     (io_rdata)
    );

    // WB-side extraction on registered read data
    load_unit i_load (
        .wb_inst    (wb_inst),
        .wb_alu     (wb_alu),
        .io_sel     (wb_io_sel),
        .dmem_rdata (dmem_rdata),
        .io_rdata   (io_rdata),
        .load_data  (wb_load_data)
    );

    // MEM/WB registers, bubble on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_pc4  <= '0;
            wb_alu  <= '0;
            wb_inst <= NOP;
        end else begin
            wb_pc4  <= pc4;
            wb_alu  <= mem_alu;
            wb_inst <= mem_inst;
        end
    end

endmodule

// ==== design/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_e;

    // Field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

endpackage

// ==== design/store_pack.sv ====
module store_pack (
    input  logic [31:0]              rd2,
    input  logic [31:0]              wdata_fwd,
    input  logic                     fwd_sel,
    input  logic [31:0]              addr,
    input  riscv_isa_pkg::mem_size_e size,
    input  logic                     is_store,
    mem_req_if.packer                req
);
    import riscv_isa_pkg::*;
    import mem_map_pkg::*;

    logic [31:0] data;
    logic [1:0]  offset;
    logic [3:0]  lane_mask;

    // Forwarded WB value wins over the register file operand
    assign data   = fwd_sel ? wdata_fwd : rd2;
    assign offset = addr[1:0];

    // Byte address down to a RAM word index
    assign req.word_addr = addr[DMEM_ADDR_BITS+1:2];

    // Replicate into every lane, the mask picks the live one
    always_comb begin
        case (size)
            SIZE_B, SIZE_BU: begin
                req.wdata = {4{data[7:0]}};
                lane_mask = 4'b0001 << offset;
            end
            SIZE_H, SIZE_HU: begin
                req.wdata = {2{data[15:0]}};
                // Halfword sits on an even lane pair
                lane_mask = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                req.wdata = data;
                lane_mask = 4'b1111;
            end
        endcase
    end

    // Loads and other instructions never write
    assign req.wmask = is_store ? lane_mask : 4'b0000;

endmodule

// ==== dv/mem_stage_sva.sv ====
module mem_stage_sva (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] mem_inst,
    input logic [3:0]  wmask,
    input logic        dmem_en,
    input logic        io_en,
    input logic [31:0] wb_inst,
    input logic [31:0] wb_pc4
);
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_isa_pkg::*;

    logic       is_store;
    logic [2:0] funct3;

    assign is_store = (mem_inst[6:0] == OPC_STORE);
    assign funct3   = mem_inst[14:12];

    // Byte store touches a single lane
    sb_mask: assert property (@(posedge clk) disable iff (!rst_n)
        (is_store && funct3 == SIZE_B) |-> $onehot(wmask))
        else $error("SB write mask %b is not one lane", wmask);

    // Halfword store on an even lane pair
    sh_mask: assert property (@(posedge clk) disable iff (!rst_n)
        (is_store && funct3 == SIZE_H) |-> (wmask == 4'b0011 || wmask == 4'b1100))
        else $error("SH write mask %b is not an aligned lane pair", wmask);

    sw_mask: assert property (@(posedge clk) disable iff (!rst_n)
        (is_store && funct3 == SIZE_W) |-> (wmask == 4'b1111))
        else $error("SW write mask %b is not all lanes", wmask);

    // Loads and everything else never write
    no_store_mask: assert property (@(posedge clk) disable iff (!rst_n)
        !is_store |-> (wmask == 4'b0000))
        else $error("Write mask %b raised without a store", wmask);

    // RAM and I/O never both selected
    one_enable: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({dmem_en, io_en}))
        else $error("RAM and I/O enables high together");

    // Held in reset, WB registers show a bubble
    reset_state: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> (wb_inst == NOP && wb_pc4 == 32'd0))
        else $error("WB registers not in reset state during reset");

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== dv/tb_mem_stage.sv ====
module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_isa_pkg::*;
    import mem_map_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int RUN_CYCLES     = 2000;
    localparam int RAM_WORDS      = 64;
    // Run length plus a quarter of margin
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

    logic        clk;
    logic        rst_n;
    logic [31:0] mem_pc;
    logic [31:0] mem_alu;
    logic [31:0] mem_rd2;
    logic [31:0] mem_inst;
    logic        mem_br_suc;
    logic [31:0] wb_wdata;
    logic [31:0] wb_pc4;
    logic [31:0] wb_alu;
    logic [31:0] wb_inst;
    logic [31:0] wb_load_data;

    // Reference model state
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] cnt_cycle;
    logic [31:0] cnt_instret;
    logic [31:0] cnt_br_total;
    logic [31:0] cnt_br_correct;
    logic [31:0] prev_inst;
    // Expected WB values for the instruction just captured
    logic [31:0] exp_pc4;
    logic [31:0] exp_alu;
    logic [31:0] exp_inst;
    logic [31:0] exp_load;
    logic        exp_is_count;
    int          cycle_count = 0;

    tb_clock i_clock (
        .clk (clk)
    );

    mem_stage i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_pc       (mem_pc),
        .mem_alu      (mem_alu),
        .mem_rd2      (mem_rd2),
        .mem_inst     (mem_inst),
        .mem_br_suc   (mem_br_suc),
        .wb_wdata     (wb_wdata),
        .wb_pc4       (wb_pc4),
        .wb_alu       (wb_alu),
        .wb_inst      (wb_inst),
        .wb_load_data (wb_load_data)
    );

    bind mem_stage mem_stage_sva i_sva (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_inst (mem_inst),
        .wmask    (req.wmask),
        .dmem_en  (req.dmem_en),
        .io_en    (req.io_en),
        .wb_inst  (wb_inst),
        .wb_pc4   (wb_pc4)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped on first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_inst(input string name, input logic [31:0] exp, input logic [31:0] act);
        opcode_e exp_opc;
        if (act !== exp) begin
            exp_opc = opcode_e'(exp[6:0]);
            fail_run($sformatf("** Error %s: expected %h (%s), actual %h",
                               name, exp, exp_opc.name(), act));
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // Few registers so rs2 often meets the last rd
    function automatic logic [31:0] make_inst(input opcode_e opc, input logic [2:0] funct3);
        logic [4:0] rd;
        logic [4:0] rs2;
        rd  = 5'($urandom_range(3, 0));
        rs2 = 5'($urandom_range(3, 0));
        return {7'($urandom), rs2, 5'($urandom), funct3, rd, opc};
    endfunction

    // Natural alignment for the access size
    function automatic logic [1:0] pick_offset(input logic [2:0] funct3);
        logic [1:0] off;
        off = 2'($urandom);
        case (funct3[1:0])
            2'b10:   off = 2'b00;
            2'b01:   off[0] = 1'b0;
            default: off = off;
        endcase
        return off;
    endfunction

    function automatic logic [2:0] pick_load_size();
        case ($urandom_range(4, 0))
            0:       return SIZE_B;
            1:       return SIZE_H;
            2:       return SIZE_W;
            3:       return SIZE_BU;
            default: return SIZE_HU;
        endcase
    endfunction

    // Reset register included, reads as zero
    function automatic logic [7:0] pick_io_reg();
        case ($urandom_range(4, 0))
            0:       return IO_CYCLE;
            1:       return IO_INSTRET;
            2:       return IO_BR_TOTAL;
            3:       return IO_BR_CORRECT;
            default: return IO_CNT_RESET;
        endcase
    endfunction

    function automatic logic [31:0] io_value(input logic [7:0] offset);
        case (offset)
            8'h10:   return cnt_cycle;
            8'h14:   return cnt_instret;
            8'h1C:   return cnt_br_total;
            8'h20:   return cnt_br_correct;
            default: return 32'd0;
        endcase
    endfunction

    // Byte or halfword picked by offset, then sign or zero fill
    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] off,
                                                input logic [2:0] funct3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8 * int'(off) +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (funct3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'd0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    // One edge of the model, on the inputs the DUT just captured
    task automatic model_step();
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [4:0]  prev_rd;
        logic        io;
        logic        prev_writes;
        logic        clear;
        logic [31:0] data;
        int          idx;
        opc     = mem_inst[6:0];
        f3      = mem_inst[14:12];
        off     = mem_alu[1:0];
        prev_rd = prev_inst[11:7];
        io      = (mem_alu[31:28] == 4'h8);
        idx     = int'(mem_alu[7:2]);
        clear   = 1'b0;
        exp_pc4      = mem_pc + 32'd4;
        exp_alu      = mem_alu;
        exp_inst     = mem_inst;
        exp_load     = 32'd0;
        exp_is_count = 1'b0;
        // Reads see state from before this edge
        if (opc == OPC_LOAD) begin
            exp_is_count = io;
            exp_load = extend_load(io ? io_value(mem_alu[7:0]) : ram[idx], off, f3);
        end
        case (prev_inst[6:0])
            OPC_LOAD, OPC_OP, OPC_OP_IMM, OPC_LUI,
            OPC_AUIPC, OPC_JAL, OPC_JALR: prev_writes = 1'b1;
            default:                      prev_writes = 1'b0;
        endcase
        // rs2 hazard on the instruction now in WB
        if (prev_writes && prev_rd != 5'd0 && prev_rd == mem_inst[24:20]) begin
            data = wb_wdata;
        end else begin
            data = mem_rd2;
        end
        if (opc == OPC_STORE && io) begin
            clear = (mem_alu[7:0] == 8'h18);
        end else if (opc == OPC_STORE) begin
            case (f3)
                3'b000:  ram[idx][8 * int'(off) +: 8] = data[7:0];
                3'b001:  ram[idx][16 * int'(off[1]) +: 16] = data[15:0];
                default: ram[idx] = data;
            endcase
        end
        if (clear) begin
            cnt_cycle      = 32'd0;
            cnt_instret    = 32'd0;
            cnt_br_total   = 32'd0;
            cnt_br_correct = 32'd0;
        end else begin
            cnt_cycle = cnt_cycle + 32'd1;
            if (prev_inst != NOP) begin
                cnt_instret = cnt_instret + 32'd1;
            end
            if (opc == OPC_BRANCH) begin
                cnt_br_total = cnt_br_total + 32'd1;
            end
            if (opc == OPC_BRANCH && mem_br_suc) begin
                cnt_br_correct = cnt_br_correct + 32'd1;
            end
        end
        prev_inst = mem_inst;
    endtask

    task automatic drive_next(input int n);
        int          pick;
        logic [5:0]  word_idx;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [31:0] inst;
        logic [31:0] alu;
        pick     = $urandom_range(99, 0);
        word_idx = 6'($urandom);
        alu      = $urandom;
        inst     = NOP;
        if (n < RAM_WORDS) begin
            // Fill the RAM window before any load
            inst = make_inst(OPC_STORE, SIZE_W);
            alu  = {24'd0, 6'(n), 2'b00};
        end else if (pick < 20) begin
            f3   = 3'($urandom_range(2, 0));
            off  = pick_offset(f3);
            inst = make_inst(OPC_STORE, f3);
            alu  = {24'd0, word_idx, off};
        end else if (pick < 22) begin
            // Counter clear
            inst = make_inst(OPC_STORE, SIZE_W);
            alu  = {IO_BASE, 20'd0, IO_CNT_RESET};
        end else if (pick < 45) begin
            f3   = pick_load_size();
            off  = pick_offset(f3);
            inst = make_inst(OPC_LOAD, f3);
            alu  = {24'd0, word_idx, off};
        end else if (pick < 55) begin
            inst = make_inst(OPC_LOAD, SIZE_W);
            alu  = {IO_BASE, 20'd0, pick_io_reg()};
        end else if (pick < 75) begin
            inst = make_inst(OPC_OP, 3'($urandom));
        end else if (pick < 90) begin
            inst = make_inst(OPC_BRANCH, 3'($urandom));
        end
        mem_inst   <= inst;
        mem_alu    <= alu;
        mem_pc     <= $urandom & 32'hFFFF_FFFC;
        mem_rd2    <= $urandom;
        wb_wdata   <= $urandom;
        mem_br_suc <= 1'($urandom);
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        void'($urandom(32'h4ad4cbf7));
        rst_n      <= 1'b0;
        mem_pc     <= 32'd0;
        mem_alu    <= 32'd0;
        mem_rd2    <= 32'd0;
        mem_inst   <= NOP;
        mem_br_suc <= 1'b0;
        wb_wdata   <= 32'd0;
        prev_inst      = NOP;
        cnt_cycle      = 32'd0;
        cnt_instret    = 32'd0;
        cnt_br_total   = 32'd0;
        cnt_br_correct = 32'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        drive_next(0);
        // Still the reset values until the next edge
        @(negedge clk);
        check_inst("reset_wb_inst", NOP, wb_inst);
        check_word("reset_wb_pc4", 32'd0, wb_pc4);
        check_word("reset_wb_alu", 32'd0, wb_alu);
        check_word("reset_wb_load_data", 32'd0, wb_load_data);
        for (int n = 1; n <= RUN_CYCLES; n++) begin
            @(posedge clk);
            model_step();
            drive_next(n);
            @(negedge clk);
            check_inst("pipe_wb_inst", exp_inst, wb_inst);
            check_word("pipe_wb_pc4", exp_pc4, wb_pc4);
            check_word("pipe_wb_alu", exp_alu, wb_alu);
            if (exp_is_count) begin
                check_count("io_counter_load", exp_load, wb_load_data);
            end else begin
                check_word("ram_load_data", exp_load, wb_load_data);
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule
